/* rtl/exec_pkg.sv */
package exec_pkg;

	typedef logic [5:0] inst_num_t;

	// *************************************************************************
	// Instruction numbers.
	// *************************************************************************
	localparam inst_num_t OP_ADD   = 6'd8;
	localparam inst_num_t OP_ADDI  = 6'd9;
	localparam inst_num_t OP_SUB   = 6'd10;
	localparam inst_num_t OP_LUI   = 6'd11;
	localparam inst_num_t OP_MUL   = 6'd12;
	localparam inst_num_t OP_MULHU = 6'd13;
	localparam inst_num_t OP_AND   = 6'd16;
	localparam inst_num_t OP_OR    = 6'd17;
	localparam inst_num_t OP_XOR   = 6'd18;
	localparam inst_num_t OP_NOR   = 6'd19;
	localparam inst_num_t OP_ANDI  = 6'd20;
	localparam inst_num_t OP_ORI   = 6'd21;
	localparam inst_num_t OP_XORI  = 6'd22;
	localparam inst_num_t OP_SLL   = 6'd23;
	localparam inst_num_t OP_SRL   = 6'd24;
	localparam inst_num_t OP_SRA   = 6'd25;
	localparam inst_num_t OP_SLT   = 6'd26;
	localparam inst_num_t OP_SLTU  = 6'd27;
	localparam inst_num_t OP_BEQ   = 6'd32;
	localparam inst_num_t OP_BNE   = 6'd33;
	localparam inst_num_t OP_BLT   = 6'd34;
	localparam inst_num_t OP_BGE   = 6'd35;
	localparam inst_num_t OP_J     = 6'd36;
	localparam inst_num_t OP_JAL   = 6'd37;
	localparam inst_num_t OP_JR    = 6'd38;

	// Category ranges, inclusive.
	localparam inst_num_t ADDSUB_FIRST = 6'd8;
	localparam inst_num_t ADDSUB_LAST  = 6'd11;
	localparam inst_num_t MULDIV_FIRST = 6'd12;
	localparam inst_num_t MULDIV_LAST  = 6'd13;
	localparam inst_num_t BIT_FIRST    = 6'd16;
	localparam inst_num_t BIT_LAST     = 6'd27;
	localparam inst_num_t BRANCH_FIRST = 6'd32;
	localparam inst_num_t BRANCH_LAST  = 6'd47;

	typedef enum logic [1:0] {
		CAT_NONE,
		CAT_ALU,
		CAT_BRANCH
	} exec_cat_e;

	// Outcome of the branch condition decode.
	typedef struct packed {
		logic taken;
		logic jump;
		logic to_rs;
	} br_result_t;

	function automatic exec_cat_e decode_cat(input inst_num_t num);
		exec_cat_e cat;
		cat = CAT_NONE;
		if ((num >= ADDSUB_FIRST && num <= ADDSUB_LAST) ||
			(num >= MULDIV_FIRST && num <= MULDIV_LAST) ||
			(num >= BIT_FIRST && num <= BIT_LAST))
			cat = CAT_ALU;
		else if (num >= BRANCH_FIRST && num <= BRANCH_LAST)
			cat = CAT_BRANCH;
		return cat;
	endfunction

endpackage

/* rtl/exec_elem_if.sv */
`timescale 1ns/1ps

interface exec_elem_if #(
	parameter int XLEN = 32
) ();

	// High while the element's category is absent or in reset.
	logic            idle;
	logic            completed;
	logic [XLEN-1:0] reg_out;
	logic [XLEN-1:0] pc_out;

	modport elem (
		input  idle,
		output completed,
		output reg_out,
		output pc_out
	);

	modport merge (
		input  idle,
		input  completed,
		input  reg_out,
		input  pc_out
	);

endinterface

/* rtl/alu_exec_element.sv */
`timescale 1ns/1ps

module alu_exec_element
	import exec_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            rst_n,
	exec_elem_if.elem       ifc,
	input  inst_num_t       inst_num,
	input  logic [XLEN-1:0] rs,
	input  logic [XLEN-1:0] rt,
	input  logic [XLEN-1:0] imm_sx,
	input  logic [15:0]     const16,
	input  logic [4:0]      shift5
);

	localparam int CW = $clog2(XLEN + 1);

	logic              busy;
	logic              done;
	logic [CW-1:0]     cnt;
	logic              start;
	logic              step;
	logic              last;
	logic              is_mul;
	logic              want_hi;
	logic [XLEN-1:0]   imm_zx;
	logic [XLEN-1:0]   alu_res;
	logic [XLEN-1:0]   reg_q;
	logic [2*XLEN-1:0] mcand;
	logic [XLEN-1:0]   mplier;
	logic [2*XLEN-1:0] prod;
	logic [2*XLEN-1:0] prod_next;

	assign is_mul = (inst_num == OP_MUL) || (inst_num == OP_MULHU);
	assign start  = !ifc.idle && !busy && !done;
	assign step   = !ifc.idle && busy;
	assign last   = (cnt == CW'(XLEN - 1));
	assign imm_zx = {{(XLEN-16){1'b0}}, const16};

	// *************************************************************************
	// Single-cycle operations.
	// *************************************************************************
	always_comb begin
		case (inst_num)
			OP_ADD:  alu_res = rs + rt;
			OP_ADDI: alu_res = rs + imm_sx;
			OP_SUB:  alu_res = rs - rt;
			OP_LUI:  alu_res = {const16, {(XLEN-16){1'b0}}};
			OP_AND:  alu_res = rs & rt;
			OP_OR:   alu_res = rs | rt;
			OP_XOR:  alu_res = rs ^ rt;
			OP_NOR:  alu_res = ~(rs | rt);
			OP_ANDI: alu_res = rs & imm_zx;
			OP_ORI:  alu_res = rs | imm_zx;
			OP_XORI: alu_res = rs ^ imm_zx;
			OP_SLL:  alu_res = rs << shift5;
			OP_SRL:  alu_res = rs >> shift5;
			OP_SRA:  alu_res = $signed(rs) >>> shift5;
			OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(rs) < $signed(rt)};
			OP_SLTU: alu_res = {{(XLEN-1){1'b0}}, rs < rt};
			default: alu_res = '0;
		endcase
	end

	// *************************************************************************
	// Shift-add multiplier, one bit of rt per cycle.
	// *************************************************************************
	assign prod_next = prod + ({(2*XLEN){mplier[0]}} & mcand);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else if (ifc.idle) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			if (is_mul) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else begin
				done <= 1'b1;
			end
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (is_mul) begin
				mcand   <= {{XLEN{1'b0}}, rs};
				mplier  <= rt;
				prod    <= '0;
				want_hi <= (inst_num == OP_MULHU);
			end else begin
				reg_q <= alu_res;
			end
		end else if (step) begin
			prod   <= prod_next;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
			if (last)
				reg_q <= want_hi ? prod_next[2*XLEN-1:XLEN] : prod_next[XLEN-1:0];
		end
	end

	assign ifc.completed = done && !ifc.idle;
	assign ifc.reg_out   = reg_q;
	assign ifc.pc_out    = '0;

	// Completion needs the element active across the previous edge.
	assert property (@(posedge clk) disable iff (!rst_n)
		ifc.completed |-> $past(!ifc.idle));

	assert property (@(posedge clk) disable iff (!rst_n)
		cnt <= CW'(XLEN));

endmodule

/* rtl/branch_exec_element.sv */
`timescale 1ns/1ps

module branch_exec_element
	import exec_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            rst_n,
	exec_elem_if.elem       ifc,
	input  inst_num_t       inst_num,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] rs,
	input  logic [XLEN-1:0] rt,
	input  logic [XLEN-1:0] imm_sx,
	input  logic [25:0]     addr26
);

	logic            done;
	logic            start;
	br_result_t      res;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] j_target;
	logic [XLEN-1:0] next_pc;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] link_q;

	assign start     = !ifc.idle && !done;
	assign pc_plus4  = pc + XLEN'(4);
	assign br_target = pc_plus4 + (imm_sx << 2);
	assign j_target  = {pc_plus4[XLEN-1 -: XLEN-28], addr26, 2'b00};

	always_comb begin
		res = '0;
		case (inst_num)
			OP_BEQ:       res.taken = (rs == rt);
			OP_BNE:       res.taken = (rs != rt);
			OP_BLT:       res.taken = ($signed(rs) < $signed(rt));
			OP_BGE:       res.taken = ($signed(rs) >= $signed(rt));
			OP_J, OP_JAL: res.jump = 1'b1;
			OP_JR:        res.to_rs = 1'b1;
			// Reserved numbers fall through to pc+4.
			default:      res = '0;
		endcase
	end

	always_comb begin
		if (res.to_rs)
			next_pc = rs;
		else if (res.jump)
			next_pc = j_target;
		else if (res.taken)
			next_pc = br_target;
		else
			next_pc = pc_plus4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (ifc.idle)
			done <= 1'b0;
		else if (start)
			done <= 1'b1;
	end

	// Link value is pc+4 for every branch, used by jal.
	always_ff @(posedge clk) begin
		if (start) begin
			pc_q   <= next_pc;
			link_q <= pc_plus4;
		end
	end

	assign ifc.completed = done && !ifc.idle;
	assign ifc.reg_out   = link_q;
	assign ifc.pc_out    = pc_q;

	// Only jr may leave a misaligned next pc.
	assert property (@(posedge clk) disable iff (!rst_n)
		ifc.completed && inst_num != OP_JR |-> ifc.pc_out[1:0] == 2'b00);

endmodule

/* rtl/exec_result_merge.sv */
`timescale 1ns/1ps

module exec_result_merge #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0] pc,
	exec_elem_if.merge      alu,
	exec_elem_if.merge      br,
	output logic            completed,
	output logic [XLEN-1:0] exec_reg_out,
	output logic [XLEN-1:0] exec_pc_out
);

	assign completed = alu.completed || br.completed;

	// ALU wins when both would claim the register result.
	always_comb begin
		if (!alu.idle)
			exec_reg_out = alu.reg_out;
		else
			exec_reg_out = br.reg_out;
	end

	// Sequential flow unless the branch element owns the pc.
	always_comb begin
		if (!br.idle)
			exec_pc_out = br.pc_out;
		else
			exec_pc_out = pc + XLEN'(4);
	end

	// *************************************************************************
	// Category decode selects at most one element.
	// *************************************************************************
	always_comb begin
		assert final (alu.idle || br.idle)
		else $error("ALU and branch elements active together");
	end

endmodule

/* rtl/executor.sv */
`timescale 1ns/1ps

module executor
	import exec_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] pc,
	input  inst_num_t       inst_num,
	input  logic [15:0]     const16,
	input  logic [4:0]      shift5,
	input  logic [25:0]     addr26,
	input  logic [XLEN-1:0] rs,
	input  logic [XLEN-1:0] rt,
	// Kept for the decoder's operand layout, no element here reads it.
	input  logic [XLEN-1:0] rd,
	output logic            completed,
	output logic [XLEN-1:0] exec_reg_out,
	output logic [XLEN-1:0] exec_pc_out
);

	exec_cat_e       cat;
	logic [XLEN-1:0] imm_sx;

	exec_elem_if #(.XLEN(XLEN)) alu_if ();
	exec_elem_if #(.XLEN(XLEN)) br_if ();

	// *************************************************************************
	// Category gating of the elements.
	// *************************************************************************
	assign cat    = decode_cat(inst_num);
	assign imm_sx = {{(XLEN-16){const16[15]}}, const16};

	assign alu_if.idle = !rst_n || (cat != CAT_ALU);
	assign br_if.idle  = !rst_n || (cat != CAT_BRANCH);

	alu_exec_element #(
		.XLEN(XLEN)
	) i_alu_exec_element (
		.clk      (clk),
		.rst_n    (rst_n),
		.ifc      (alu_if),
		.inst_num (inst_num),
		.rs       (rs),
		.rt       (rt),
		.imm_sx   (imm_sx),
		.const16  (const16),
		.shift5   (shift5)
	);

	branch_exec_element #(
		.XLEN(XLEN)
	) i_branch_exec_element (
		.clk      (clk),
		.rst_n    (rst_n),
		.ifc      (br_if),
		.inst_num (inst_num),
		.pc       (pc),
		.rs       (rs),
		.rt       (rt),
		.imm_sx   (imm_sx),
		.addr26   (addr26)
	);

	exec_result_merge #(
		.XLEN(XLEN)
	) i_exec_result_merge (
		.pc           (pc),
		.alu          (alu_if),
		.br           (br_if),
		.completed    (completed),
		.exec_reg_out (exec_reg_out),
		.exec_pc_out  (exec_pc_out)
	);

endmodule

/* include/executor_vectors.svh */
`ifndef EXECUTOR_VECTORS_SVH
`define EXECUTOR_VECTORS_SVH

// Each row gives inst_num, pc, const16, shift5, addr26, rs, rt,
// then the expected reg_out and the expected pc_out.
typedef struct packed {
	inst_num_t       num;
	logic [XLEN-1:0] pc;
	logic [15:0]     c16;
	logic [4:0]      sh;
	logic [25:0]     a26;
	logic [XLEN-1:0] rs;
	logic [XLEN-1:0] rt;
	logic [XLEN-1:0] exp_reg;
	logic [XLEN-1:0] exp_pc;
} vec_t;

vec_t vec_q[$];

task automatic add_row(input inst_num_t num, input logic [XLEN-1:0] pc, input logic [15:0] c16,
	input logic [4:0] sh, input logic [25:0] a26, input logic [XLEN-1:0] rs, rt, exp_reg, exp_pc);
	vec_q.push_back({num, pc, c16, sh, a26, rs, rt, exp_reg, exp_pc});
endtask

task automatic fill_table();
	// Add, sub and immediates.
	add_row(OP_ADD,   'h1000, 'h0,    0,  'h0, 'h7fffffff, 'h1,        'h80000000, 'h1004);
	add_row(OP_SUB,   'h1000, 'h0,    0,  'h0, 'h5,        'h7,        'hfffffffe, 'h1004);
	add_row(OP_ADDI,  'h1000, 'hfff0, 0,  'h0, 'h100,      'h0,        'hf0,       'h1004);
	add_row(OP_LUI,   'h1000, 'hbeef, 0,  'h0, 'h0,        'h0,        'hbeef0000, 'h1004);
	// Bitwise, shift and compare.
	add_row(OP_AND,   'h1000, 'h0,    0,  'h0, 'hf0f0ff00, 'hff00f0f0, 'hf000f000, 'h1004);
	add_row(OP_OR,    'h1000, 'h0,    0,  'h0, 'hf0f00000, 'h0f0000ff, 'hfff000ff, 'h1004);
	add_row(OP_XOR,   'h1000, 'h0,    0,  'h0, 'haaaa5555, 'hffff0000, 'h55555555, 'h1004);
	add_row(OP_NOR,   'h1000, 'h0,    0,  'h0, 'h0f0f0000, 'h000000f0, 'hf0f0ff0f, 'h1004);
	add_row(OP_ANDI,  'h1000, 'h8001, 0,  'h0, 'hffffffff, 'h0,        'h00008001, 'h1004);
	add_row(OP_ORI,   'h1000, 'hffff, 0,  'h0, 'h12340000, 'h0,        'h1234ffff, 'h1004);
	add_row(OP_XORI,  'h1000, 'h00ff, 0,  'h0, 'hffffffff, 'h0,        'hffffff00, 'h1004);
	add_row(OP_SLL,   'h1000, 'h0,    31, 'h0, 'h3,        'h0,        'h80000000, 'h1004);
	add_row(OP_SRL,   'h1000, 'h0,    4,  'h0, 'h80000000, 'h0,        'h08000000, 'h1004);
	add_row(OP_SRA,   'h1000, 'h0,    4,  'h0, 'h80000010, 'h0,        'hf8000001, 'h1004);
	add_row(OP_SLT,   'h1000, 'h0,    0,  'h0, 'h80000000, 'h1,        'h1,        'h1004);
	add_row(OP_SLTU,  'h1000, 'h0,    0,  'h0, 'h80000000, 'h1,        'h0,        'h1004);
	// Multiplier.
	add_row(OP_MUL,   'h1000, 'h0,    0,  'h0, 'hffffffff, 'hffffffff, 'h00000001, 'h1004);
	add_row(OP_MULHU, 'h1000, 'h0,    0,  'h0, 'hffffffff, 'hffffffff, 'hfffffffe, 'h1004);
	add_row(OP_MUL,   'h1000, 'h0,    0,  'h0, 'h00010000, 'h00010003, 'h00030000, 'h1004);
	// Conditional branches, taken and not taken.
	add_row(OP_BEQ,   'h2000, 'hfffc, 0,  'h0, 'h5,        'h5,        'h2004,     'h1ff4);
	add_row(OP_BEQ,   'h2000, 'hfffc, 0,  'h0, 'h5,        'h6,        'h2004,     'h2004);
	add_row(OP_BNE,   'h2000, 'h0010, 0,  'h0, 'h5,        'h6,        'h2004,     'h2044);
	add_row(OP_BNE,   'h2000, 'h0010, 0,  'h0, 'h9,        'h9,        'h2004,     'h2004);
	add_row(OP_BLT,   'h2000, 'hfff8, 0,  'h0, 'hffffffff, 'h1,        'h2004,     'h1fe4);
	add_row(OP_BLT,   'h2000, 'hfff8, 0,  'h0, 'h1,        'hffffffff, 'h2004,     'h2004);
	add_row(OP_BGE,   'h2000, 'hfff8, 0,  'h0, 'h1,        'hffffffff, 'h2004,     'h1fe4);
	add_row(OP_BGE,   'h2000, 'hfff8, 0,  'h0, 'hffffffff, 'h1,        'h2004,     'h2004);
	// Jumps and a reserved branch number.
	add_row(OP_J,   'ha0000000, 'h0, 0, 'h0123456, 'h0,    'h0, 'ha0000004, 'ha048d158);
	add_row(OP_JAL, 'h40000ffc, 'h0, 0, 'h3ffffff, 'h0,    'h0, 'h40001000, 'h4ffffffc);
	add_row(OP_JR,  'h00002000, 'h0, 0, 'h0,       'h3002, 'h0, 'h00002004, 'h00003002);
	add_row(6'd40,  'h00002000, 'h0, 0, 'h0,       'h7,    'h7, 'h00002004, 'h00002004);
endtask

`endif

/* verification/tb_executor.sv */
`timescale 1ns/1ps

module tb_executor
	import exec_pkg::*;
();

	localparam int XLEN         = 32;
	localparam int RESET_CYCLES = 3;

	logic            clk;
	logic            rst_n;
	logic [XLEN-1:0] pc;
	inst_num_t       inst_num;
	logic [15:0]     const16;
	logic [4:0]      shift5;
	logic [25:0]     addr26;
	logic [XLEN-1:0] rs;
	logic [XLEN-1:0] rt;
	logic [XLEN-1:0] rd;
	logic            completed;
	logic [XLEN-1:0] exec_reg_out;
	logic [XLEN-1:0] exec_pc_out;

	int          errors;
	int          checks;
	int          tests;
	int          cycle_cnt;
	int          cycle_limit;
	logic [15:0] lfsr;

	`include "executor_vectors.svh"

	executor #(
		.XLEN(XLEN)
	) i_executor (
		.clk          (clk),
		.rst_n        (rst_n),
		.pc           (pc),
		.inst_num     (inst_num),
		.const16      (const16),
		.shift5       (shift5),
		.addr26       (addr26),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.completed    (completed),
		.exec_reg_out (exec_reg_out),
		.exec_pc_out  (exec_pc_out)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the DUT did not complete within %0d cycles", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// *************************************************************************
	// Reference model and helpers.
	// *************************************************************************
	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [XLEN-1:0] w);
		w = '0;
		for (int i = 0; i < XLEN; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[XLEN-2:0], lfsr[0]};
		end
	endtask

	function automatic logic [XLEN-1:0] expect_alu(input vec_t v);
		logic [2*XLEN-1:0] prod;
		logic [XLEN-1:0]   zx;
		logic [XLEN-1:0]   sx;
		prod = {{XLEN{1'b0}}, v.rs} * {{XLEN{1'b0}}, v.rt};
		zx = {{(XLEN-16){1'b0}}, v.c16};
		sx = {{(XLEN-16){v.c16[15]}}, v.c16};
		case (v.num)
			OP_ADD:   return v.rs + v.rt;
			OP_ADDI:  return v.rs + sx;
			OP_SUB:   return v.rs - v.rt;
			OP_LUI:   return {v.c16, {(XLEN-16){1'b0}}};
			OP_MUL:   return prod[XLEN-1:0];
			OP_MULHU: return prod[2*XLEN-1:XLEN];
			OP_AND:   return v.rs & v.rt;
			OP_OR:    return v.rs | v.rt;
			OP_XOR:   return v.rs ^ v.rt;
			OP_NOR:   return ~(v.rs | v.rt);
			OP_ANDI:  return v.rs & zx;
			OP_ORI:   return v.rs | zx;
			OP_XORI:  return v.rs ^ zx;
			OP_SLL:   return v.rs << v.sh;
			OP_SRL:   return v.rs >> v.sh;
			OP_SRA:   return $signed(v.rs) >>> v.sh;
			OP_SLT:   return ($signed(v.rs) < $signed(v.rt)) ? 1 : 0;
			OP_SLTU:  return (v.rs < v.rt) ? 1 : 0;
			default:  return '0;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_quiet();
		check_value("completed while quiet", completed, 1'b0);
		check_value("exec_pc_out while quiet", exec_pc_out, pc + XLEN'(4));
	endtask

	task automatic drive(input vec_t v);
		inst_num = v.num;
		pc       = v.pc;
		const16  = v.c16;
		shift5   = v.sh;
		addr26   = v.a26;
		rs       = v.rs;
		rt       = v.rt;
	endtask

	task automatic run_entry(input vec_t v);
		int lat;
		int exp_lat;
		int errs_before;
		errs_before = errors;
		exp_lat = (v.num == OP_MUL || v.num == OP_MULHU) ? XLEN + 1 : 1;
		@(posedge clk);
		#2;
		drive(v);
		@(negedge clk);
		check_value("completed before sampling", completed, 1'b0);
		// Edge that samples the instruction.
		@(posedge clk);
		@(negedge clk);
		lat = 1;
		while (!completed) begin
			@(negedge clk);
			lat++;
		end
		check_value("exec_reg_out", exec_reg_out, v.exp_reg);
		check_value("exec_pc_out", exec_pc_out, v.exp_pc);
		check_value("completion latency", lat, exp_lat);
		// One no-op cycle before the next instruction.
		@(posedge clk);
		#2;
		inst_num = '0;
		@(negedge clk);
		check_quiet();
		tests++;
		$display("test %0d op %0d: %s", tests, v.num, (errors == errs_before) ? "ok" : "failed");
	endtask

	// *************************************************************************
	// Main sequence.
	// *************************************************************************
	initial begin
		vec_t            v;
		logic [XLEN-1:0] r;
		int              n_alu;
		rst_n       = 1'b0;
		pc          = '0;
		inst_num    = '0;
		const16     = '0;
		shift5      = '0;
		addr26      = '0;
		rs          = '0;
		rt          = '0;
		rd          = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		cycle_cnt   = 0;
		lfsr        = 16'd17;
		fill_table();
		n_alu = 0;
		foreach (vec_q[i])
			if (vec_q[i].num < OP_BEQ)
				n_alu++;
		cycle_limit = (vec_q.size() + n_alu) * (XLEN + 4) + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_quiet();

		foreach (vec_q[i])
			run_entry(vec_q[i]);

		// ALU rows again with LFSR operands.
		foreach (vec_q[i]) begin
			if (vec_q[i].num < OP_BEQ) begin
				v = vec_q[i];
				random_word(r);
				v.rs = r;
				random_word(r);
				v.rt = r;
				v.exp_reg = expect_alu(v);
				v.exp_pc = v.pc + XLEN'(4);
				run_entry(v);
			end
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
rtl/exec_pkg.sv
rtl/exec_elem_if.sv
rtl/alu_exec_element.sv
rtl/branch_exec_element.sv
rtl/exec_result_merge.sv
rtl/executor.sv
verification/tb_executor.sv

/* Bender.yml */
package:
  name: executor

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/exec_elem_if.sv
      - rtl/alu_exec_element.sv
      - rtl/branch_exec_element.sv
      - rtl/exec_result_merge.sv
      - rtl/executor.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_executor.sv
